// ==== src/gen_pkg.sv ====
`default_nettype none

package gen_pkg;

    ////////////////////
    // vector types

    // full host address, region nibble on top
    typedef logic [11:0] bus_addr_t;
    // register offset inside a region
    typedef logic [7:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    // msb..lsb: att 3 dB, att1 10 dB, att2 10 dB, gain x5
    typedef logic [3:0]  atten_t;
    typedef logic [15:0] dac_word_t;
    typedef logic [2:0]  hw_rev_t;
    typedef logic [2:0]  pn_state_t;

    // upper address nibble, other codes unmapped
    typedef enum logic [3:0] {
        REGION_CH1   = 4'd0,
        REGION_CH2   = 4'd1,
        REGION_SHARE = 4'd2
    } region_e;

    ////////////////////
    // bundles

    // one decoded host write, we is a single-cycle pulse
    typedef struct packed {
        logic      we;
        region_e   region;
        reg_addr_t addr;
        reg_data_t data;
    } cfg_write_t;

    // per-channel control state
    typedef struct packed {
        logic   on_off;
        atten_t atten;
        logic   protect;
    } chan_ctrl_t;

    ////////////////////
    // address map

    // channel region offsets
    localparam reg_addr_t ADDR_CH_ON_OFF  = 8'h00;
    localparam reg_addr_t ADDR_CH_ATTEN   = 8'h01;
    // shared region offsets
    localparam reg_addr_t ADDR_HW_REV     = 8'h00;
    localparam reg_addr_t ADDR_STATUS     = 8'h01;
    localparam reg_addr_t ADDR_PN_RATE    = 8'h10;
    localparam reg_addr_t ADDR_PN_RESTART = 8'h11;

    // pn / dac constants
    localparam pn_state_t PN_SEED      = 3'b111;
    localparam dac_word_t DAC_POS_FULL = 16'h7FFF;
    localparam dac_word_t DAC_NEG_FULL = 16'h8000;
    localparam dac_word_t DAC_MID      = 16'h0000;

    // input synchronizer depth
    localparam int SYNC_STAGES = 2;

endpackage

`default_nettype wire

// ==== src/host_bus_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_bus_decode (
    input  logic                clk_low,
    input  logic                rst_n,
    input  logic                bus_cs_n,
    input  logic                bus_we_n,
    input  logic                bus_oe_n,
    input  gen_pkg::bus_addr_t  bus_addr,
    input  gen_pkg::reg_data_t  bus_wdata,
    output gen_pkg::cfg_write_t cfg_wr,
    output logic                rd_req,
    output gen_pkg::region_e    rd_region,
    output gen_pkg::reg_addr_t  rd_addr
);
    import gen_pkg::*;

    // strobe synchronizers, oldest sample at the top bit
    logic [SYNC_STAGES-1:0] cs_sync;
    logic [SYNC_STAGES-1:0] we_sync;
    logic [SYNC_STAGES-1:0] oe_sync;
    logic                   we_last;
    logic                   we_fall;
    logic                   wr_pulse;
    region_e                wr_region;
    reg_addr_t              wr_addr;
    reg_data_t              wr_data;

    ////////////////////
    // strobe sync

    // all strobes idle high
    always_ff @(posedge clk_low or negedge rst_n) begin
        if (!rst_n) begin
            cs_sync <= '1;
            we_sync <= '1;
            oe_sync <= '1;
            we_last <= 1'b1;
        end else begin
            cs_sync <= {cs_sync[SYNC_STAGES-2:0], bus_cs_n};
            we_sync <= {we_sync[SYNC_STAGES-2:0], bus_we_n};
            oe_sync <= {oe_sync[SYNC_STAGES-2:0], bus_oe_n};
            we_last <= we_sync[SYNC_STAGES-1];
        end
    end

    // nWE high->low with chip select held low
    assign we_fall = we_last & ~we_sync[SYNC_STAGES-1] & ~cs_sync[SYNC_STAGES-1];

    ////////////////////
    // write capture

    always_ff @(posedge clk_low or negedge rst_n) begin
        if (!rst_n) begin
            wr_pulse <= 1'b0;
            rd_req   <= 1'b0;
        end else begin
            wr_pulse <= we_fall;
            // read open while both cs and oe sit low
            rd_req   <= ~cs_sync[SYNC_STAGES-1] & ~oe_sync[SYNC_STAGES-1];
        end
    end

    // pins are stable for the whole bus phase, grab them at the edge
    always_ff @(posedge clk_low) begin
        if (we_fall) begin
            wr_region <= region_e'(bus_addr[11:8]);
            wr_addr   <= bus_addr[7:0];
            wr_data   <= bus_wdata;
        end
        // read address sampled every cycle, data follows one cycle later
        rd_region <= region_e'(bus_addr[11:8]);
        rd_addr   <= bus_addr[7:0];
    end

    assign cfg_wr = '{we: wr_pulse, region: wr_region, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// ==== src/channel_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module channel_regs (
    input  logic                clk_low,
    input  logic                rst_n,
    input  logic                load_protect,
    input  gen_pkg::region_e    region_sel,
    input  gen_pkg::cfg_write_t cfg_wr,
    output gen_pkg::chan_ctrl_t ctrl
);
    import gen_pkg::*;

    logic [SYNC_STAGES-1:0] protect_sync;
    logic                   protect_s;
    logic                   chan_hit;
    logic                   enable_reg;
    atten_t                 atten_reg;

    // load protect comes straight from the output stage comparator
    always_ff @(posedge clk_low or negedge rst_n) begin
        if (!rst_n) begin
            protect_sync <= '0;
        end else begin
            protect_sync <= {protect_sync[SYNC_STAGES-2:0], load_protect};
        end
    end

    assign protect_s = protect_sync[SYNC_STAGES-1];

    // only writes aimed at this channel
    assign chan_hit = cfg_wr.we && (cfg_wr.region == region_sel);

    ////////////////////
    // register file

    always_ff @(posedge clk_low or negedge rst_n) begin
        if (!rst_n) begin
            enable_reg <= 1'b0;
            atten_reg  <= '0;
        end else if (chan_hit) begin
            case (cfg_wr.addr)
                ADDR_CH_ON_OFF: enable_reg <= cfg_wr.data[0];
                ADDR_CH_ATTEN:  atten_reg  <= cfg_wr.data[3:0];
                default: ;
            endcase
        end
    end

    // stored enable kept, output forced off while protected
    assign ctrl.on_off  = enable_reg & ~protect_s;
    assign ctrl.atten   = atten_reg;
    assign ctrl.protect = protect_s;

endmodule

`default_nettype wire

// ==== src/shared_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module shared_regs (
    input  logic                clk_low,
    input  logic                rst_n,
    input  gen_pkg::cfg_write_t cfg_wr,
    input  gen_pkg::hw_rev_t    hw_rev,
    input  logic                ext_clk_valid,
    input  gen_pkg::chan_ctrl_t ch1_ctrl,
    input  gen_pkg::chan_ctrl_t ch2_ctrl,
    output gen_pkg::reg_data_t  pn_rate,
    output logic                pn_restart,
    output gen_pkg::reg_data_t  status
);
    import gen_pkg::*;

    logic [SYNC_STAGES-1:0] ext_sync;
    logic                   share_hit;

    assign share_hit = cfg_wr.we && (cfg_wr.region == REGION_SHARE);

    // ext 10 MHz detect lives in another domain on the board
    always_ff @(posedge clk_low or negedge rst_n) begin
        if (!rst_n) begin
            ext_sync <= '0;
        end else begin
            ext_sync <= {ext_sync[SYNC_STAGES-2:0], ext_clk_valid};
        end
    end

    ////////////////////
    // pn control

    always_ff @(posedge clk_low or negedge rst_n) begin
        if (!rst_n) begin
            pn_rate    <= '0;
            pn_restart <= 1'b0;
        end else begin
            // any data value restarts
            pn_restart <= share_hit && (cfg_wr.addr == ADDR_PN_RESTART);
            if (share_hit && (cfg_wr.addr == ADDR_PN_RATE)) begin
                pn_rate <= cfg_wr.data;
            end
        end
    end

    // status byte
    // bit0 ext clk valid, bit1 ch1 protect, bit2 ch2 protect, hw rev above
    assign status = {2'b00, hw_rev, ch2_ctrl.protect, ch1_ctrl.protect,
                     ext_sync[SYNC_STAGES-1]};

endmodule

`default_nettype wire

// ==== src/pn3_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pn3_gen (
    input  logic               clk_low,
    input  logic               rst_n,
    input  gen_pkg::reg_data_t pn_rate,
    input  logic               pn_restart,
    output logic               chip
);
    import gen_pkg::*;

    reg_data_t div_cnt;
    pn_state_t lfsr;
    logic      step;
    logic      feedback;

    // >= so a rate lowered mid-count does not run the counter round
    assign step = (div_cnt >= pn_rate);

    // taps on bits 2 and 1, shifted in at the bottom
    assign feedback = lfsr[2] ^ lfsr[1];

    ////////////////////
    // divider + lfsr

    always_ff @(posedge clk_low or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            lfsr    <= PN_SEED;
        end else if (pn_restart) begin
            div_cnt <= '0;
            lfsr    <= PN_SEED;
        end else if (step) begin
            // one chip every pn_rate + 1 cycles
            div_cnt <= '0;
            lfsr    <= {lfsr[1:0], feedback};
        end else begin
            div_cnt <= div_cnt + 8'd1;
        end
    end

    // from seed 111: 1,1,1,0,0,1,0
    assign chip = lfsr[2];

endmodule

`default_nettype wire

// ==== src/readback_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module readback_mux (
    input  logic                clk_low,
    input  logic                rst_n,
    input  logic                rd_req,
    input  gen_pkg::region_e    rd_region,
    input  gen_pkg::reg_addr_t  rd_addr,
    input  gen_pkg::chan_ctrl_t ch1_ctrl,
    input  gen_pkg::chan_ctrl_t ch2_ctrl,
    input  gen_pkg::hw_rev_t    hw_rev,
    input  gen_pkg::reg_data_t  status,
    input  gen_pkg::reg_data_t  pn_rate,
    output gen_pkg::reg_data_t  bus_rdata,
    output logic                bus_rdata_oe
);
    import gen_pkg::*;

    reg_data_t rd_sel;

    // same offset map for both channels
    function automatic reg_data_t chan_read(input chan_ctrl_t c, input reg_addr_t a);
        reg_data_t d;
        case (a)
            ADDR_CH_ON_OFF: d = {7'b0, c.on_off};
            ADDR_CH_ATTEN:  d = {4'b0, c.atten};
            default:        d = '0;
        endcase
        return d;
    endfunction

    ////////////////////
    // select

    always_comb begin
        rd_sel = '0;
        case (rd_region)
            REGION_CH1: rd_sel = chan_read(ch1_ctrl, rd_addr);
            REGION_CH2: rd_sel = chan_read(ch2_ctrl, rd_addr);
            REGION_SHARE: begin
                case (rd_addr)
                    ADDR_HW_REV:  rd_sel = {5'b0, hw_rev};
                    ADDR_STATUS:  rd_sel = status;
                    ADDR_PN_RATE: rd_sel = pn_rate;
                    default:      rd_sel = '0;
                endcase
            end
            // unmapped region reads zero
            default: rd_sel = '0;
        endcase
    end

    // oe to the pad ring
    always_ff @(posedge clk_low or negedge rst_n) begin
        if (!rst_n) begin
            bus_rdata_oe <= 1'b0;
        end else begin
            bus_rdata_oe <= rd_req;
        end
    end

    // bus idles at zero between reads
    always_ff @(posedge clk_low) begin
        bus_rdata <= rd_req ? rd_sel : '0;
    end

endmodule

`default_nettype wire

// ==== src/dac_word_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module dac_word_map (
    input  logic                clk_low,
    input  logic                rst_n,
    input  logic                chip,
    input  gen_pkg::chan_ctrl_t ch1_ctrl,
    input  gen_pkg::chan_ctrl_t ch2_ctrl,
    output gen_pkg::dac_word_t  dac_data_ch1,
    output gen_pkg::dac_word_t  dac_data_ch2
);
    import gen_pkg::*;

    // chip to +/- full scale, midscale when the channel is off
    function automatic dac_word_t chip_to_word(input logic c, input logic on);
        dac_word_t w;
        if (!on) begin
            w = DAC_MID;
        end else if (c) begin
            w = DAC_POS_FULL;
        end else begin
            w = DAC_NEG_FULL;
        end
        return w;
    endfunction

    ////////////////////
    // output regs

    // one cycle after the chip
    always_ff @(posedge clk_low or negedge rst_n) begin
        if (!rst_n) begin
            dac_data_ch1 <= DAC_MID;
            dac_data_ch2 <= DAC_MID;
        end else begin
            dac_data_ch1 <= chip_to_word(chip, ch1_ctrl.on_off);
            dac_data_ch2 <= chip_to_word(chip, ch2_ctrl.on_off);
        end
    end

endmodule

`default_nettype wire

// ==== src/signal_gen_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module signal_gen_top (
    input  logic               clk_low,
    input  logic               rst_n,
    // host bus, strobes active low
    input  logic               bus_cs_n,
    input  logic               bus_we_n,
    input  logic               bus_oe_n,
    input  gen_pkg::bus_addr_t bus_addr,
    input  gen_pkg::reg_data_t bus_wdata,
    // board status inputs
    input  gen_pkg::hw_rev_t   hw_rev,
    input  logic               ext_clk_valid,
    input  logic               ch1_load_protect,
    input  logic               ch2_load_protect,
    // read side, tristate lives in the pad ring
    output gen_pkg::reg_data_t bus_rdata,
    output logic               bus_rdata_oe,
    // channel relays
    output logic               ch1_on_off,
    output logic               ch2_on_off,
    output gen_pkg::atten_t    ch1_atten,
    output gen_pkg::atten_t    ch2_atten,
    // dac words
    output gen_pkg::dac_word_t dac_data_ch1,
    output gen_pkg::dac_word_t dac_data_ch2
);
    import gen_pkg::*;

    cfg_write_t cfg_wr;
    logic       rd_req;
    region_e    rd_region;
    reg_addr_t  rd_addr;
    chan_ctrl_t ch1_ctrl;
    chan_ctrl_t ch2_ctrl;
    reg_data_t  pn_rate;
    logic       pn_restart;
    reg_data_t  status;
    logic       chip;

    // relay pins straight from channel state
    assign ch1_on_off = ch1_ctrl.on_off;
    assign ch2_on_off = ch2_ctrl.on_off;
    assign ch1_atten  = ch1_ctrl.atten;
    assign ch2_atten  = ch2_ctrl.atten;

    ////////////////////
    // host side

    host_bus_decode u_host_bus_decode (
        .clk_low   (clk_low),
        .rst_n     (rst_n),
        .bus_cs_n  (bus_cs_n),
        .bus_we_n  (bus_we_n),
        .bus_oe_n  (bus_oe_n),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .cfg_wr    (cfg_wr),
        .rd_req    (rd_req),
        .rd_region (rd_region),
        .rd_addr   (rd_addr)
    );

    // channel 1 regs
    channel_regs u0_channel_regs (
        .clk_low      (clk_low),
        .rst_n        (rst_n),
        .load_protect (ch1_load_protect),
        .region_sel   (REGION_CH1),
        .cfg_wr       (cfg_wr),
        .ctrl         (ch1_ctrl)
    );

    // channel 2 regs
    channel_regs u1_channel_regs (
        .clk_low      (clk_low),
        .rst_n        (rst_n),
        .load_protect (ch2_load_protect),
        .region_sel   (REGION_CH2),
        .cfg_wr       (cfg_wr),
        .ctrl         (ch2_ctrl)
    );

    shared_regs u_shared_regs (
        .clk_low       (clk_low),
        .rst_n         (rst_n),
        .cfg_wr        (cfg_wr),
        .hw_rev        (hw_rev),
        .ext_clk_valid (ext_clk_valid),
        .ch1_ctrl      (ch1_ctrl),
        .ch2_ctrl      (ch2_ctrl),
        .pn_rate       (pn_rate),
        .pn_restart    (pn_restart),
        .status        (status)
    );

    readback_mux u_readback_mux (
        .clk_low      (clk_low),
        .rst_n        (rst_n),
        .rd_req       (rd_req),
        .rd_region    (rd_region),
        .rd_addr      (rd_addr),
        .ch1_ctrl     (ch1_ctrl),
        .ch2_ctrl     (ch2_ctrl),
        .hw_rev       (hw_rev),
        .status       (status),
        .pn_rate      (pn_rate),
        .bus_rdata    (bus_rdata),
        .bus_rdata_oe (bus_rdata_oe)
    );

    ////////////////////
    // pattern path

    // one pn source shared by both channels
    pn3_gen u_pn3_gen (
        .clk_low    (clk_low),
        .rst_n      (rst_n),
        .pn_rate    (pn_rate),
        .pn_restart (pn_restart),
        .chip       (chip)
    );

    dac_word_map u_dac_word_map (
        .clk_low      (clk_low),
        .rst_n        (rst_n),
        .chip         (chip),
        .ch1_ctrl     (ch1_ctrl),
        .ch2_ctrl     (ch2_ctrl),
        .dac_data_ch1 (dac_data_ch1),
        .dac_data_ch2 (dac_data_ch2)
    );

endmodule

`default_nettype wire

// ==== bench/tb_signal_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_signal_gen;
    import gen_pkg::*;

    localparam int        PHASE_CYCLES    = 8;
    localparam int        CYCLES_PER_LINE = 40;
    localparam int        WATCH_MARGIN    = 200;
    localparam int        GATE_CYCLES     = 40;
    localparam hw_rev_t   BOARD_REV       = 3'd5;
    localparam dac_word_t POS_WORD        = 16'h7FFF;
    localparam dac_word_t NEG_WORD        = 16'h8000;
    localparam dac_word_t MID_WORD        = 16'h0000;

    logic       clk_low;
    logic       rst_n;
    logic       bus_cs_n;
    logic       bus_we_n;
    logic       bus_oe_n;
    bus_addr_t  bus_addr;
    reg_data_t  bus_wdata;
    hw_rev_t    hw_rev;
    logic       ext_clk_valid;
    logic       ch1_load_protect;
    logic       ch2_load_protect;
    reg_data_t  bus_rdata;
    logic       bus_rdata_oe;
    logic       ch1_on_off;
    logic       ch2_on_off;
    atten_t     ch1_atten;
    atten_t     ch2_atten;
    dac_word_t  dac_data_ch1;
    dac_word_t  dac_data_ch2;

    // test lines from the data file
    string      op_q[$];
    int         addr_q[$];
    int         val_q[$];
    logic       loaded = 1'b0;
    int         err_count = 0;
    int         test_fails = 0;
    int         seed = 10522;

    signal_gen_top dut0 (
        .clk_low          (clk_low),
        .rst_n            (rst_n),
        .bus_cs_n         (bus_cs_n),
        .bus_we_n         (bus_we_n),
        .bus_oe_n         (bus_oe_n),
        .bus_addr         (bus_addr),
        .bus_wdata        (bus_wdata),
        .hw_rev           (hw_rev),
        .ext_clk_valid    (ext_clk_valid),
        .ch1_load_protect (ch1_load_protect),
        .ch2_load_protect (ch2_load_protect),
        .bus_rdata        (bus_rdata),
        .bus_rdata_oe     (bus_rdata_oe),
        .ch1_on_off       (ch1_on_off),
        .ch2_on_off       (ch2_on_off),
        .ch1_atten        (ch1_atten),
        .ch2_atten        (ch2_atten),
        .dac_data_ch1     (dac_data_ch1),
        .dac_data_ch2     (dac_data_ch2)
    );

    // 4 ns clock
    initial begin
        clk_low = 1'b0;
        forever #2 clk_low = ~clk_low;
    end

    ////////////////////
    // compare tasks

    task automatic check_reg(input string name, input reg_data_t exp, input reg_data_t act);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_atten(input string name, input atten_t exp, input atten_t act);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s expected 0x%01h, got 0x%01h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_dac(input string name, input dac_word_t exp, input dac_word_t act);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s expected 0x%04h, got 0x%04h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s expected %b, got %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    ////////////////////
    // bus phases

    // cs and we low for one phase then one idle phase
    task automatic bus_write(input bus_addr_t addr, input reg_data_t data);
        @(negedge clk_low);
        bus_addr  = addr;
        bus_wdata = data;
        bus_cs_n  = 1'b0;
        bus_we_n  = 1'b0;
        repeat (PHASE_CYCLES) @(negedge clk_low);
        bus_cs_n = 1'b1;
        bus_we_n = 1'b1;
        repeat (PHASE_CYCLES) @(negedge clk_low);
    endtask

    // data checked at the end of the read phase and oe again after idle
    task automatic bus_read(input bus_addr_t addr, input reg_data_t exp);
        @(negedge clk_low);
        bus_addr = addr;
        bus_cs_n = 1'b0;
        bus_oe_n = 1'b0;
        repeat (PHASE_CYCLES) @(negedge clk_low);
        check_bit("bus_rdata_oe", 1'b1, bus_rdata_oe);
        check_reg("bus_rdata", exp, bus_rdata);
        bus_cs_n = 1'b1;
        bus_oe_n = 1'b1;
        repeat (PHASE_CYCLES) @(negedge clk_low);
        check_bit("bus_rdata_oe", 1'b0, bus_rdata_oe);
    endtask

    task automatic set_protect(input int chan, input logic level);
        @(negedge clk_low);
        if (chan == 1) begin
            ch1_load_protect = level;
        end else begin
            ch2_load_protect = level;
        end
        repeat (PHASE_CYCLES) @(negedge clk_low);
    endtask

    task automatic set_ext_clk(input logic level);
        @(negedge clk_low);
        ext_clk_valid = level;
        repeat (PHASE_CYCLES) @(negedge clk_low);
    endtask

    ////////////////////
    // pn checks

    // period 1,1,1,0,0,1,0 from the seed
    function automatic logic pn_ref_chip(input int idx);
        case (idx % 7)
            0, 1, 2, 5: return 1'b1;
            default:    return 1'b0;
        endcase
    endfunction

    task automatic check_pn_sequence(input int rate);
        dac_word_t s1[$];
        dac_word_t s2[$];
        logic      chips[$];
        dac_word_t exp;
        int        span;
        int        t0;
        int        rot;
        int        run;
        bit        match;
        span = rate + 1;
        bus_write({REGION_SHARE, ADDR_PN_RATE}, reg_data_t'(rate));
        bus_write({REGION_SHARE, ADDR_PN_RESTART}, 8'h00);
        // enough for a partial leading run plus 21 whole chips
        repeat (25 * span) begin
            @(negedge clk_low);
            if (dac_data_ch1 !== POS_WORD && dac_data_ch1 !== NEG_WORD) begin
                $display("Fail at %0d ns: dac_data_ch1 expected 0x%04h or 0x%04h, got 0x%04h",
                         $time, POS_WORD, NEG_WORD, dac_data_ch1);
                err_count++;
            end
            s1.push_back(dac_data_ch1);
            s2.push_back(dac_data_ch2);
        end
        // first change marks a chip boundary
        t0 = 0;
        for (int i = 1; i < s1.size() && t0 == 0; i++) begin
            if (s1[i] != s1[i-1]) t0 = i;
        end
        if (t0 == 0) begin
            $display("error: dac_data_ch1 never changed during the PN capture");
            err_count++;
            return;
        end
        for (int k = 0; k < 7; k++) begin
            chips.push_back(s1[t0 + k * span] == POS_WORD);
        end
        // find the phase of the reference period
        rot = -1;
        for (int r = 0; r < 7; r++) begin
            match = 1'b1;
            for (int k = 0; k < 7; k++) begin
                if (chips[k] != pn_ref_chip(r + k)) match = 1'b0;
            end
            if (match) rot = r;
        end
        if (rot < 0) begin
            $display("error: chip sequence is not a rotation of 1,1,1,0,0,1,0");
            err_count++;
            return;
        end
        // both channels follow the same chip stream
        for (int i = t0; i < t0 + 21 * span; i++) begin
            exp = pn_ref_chip(rot + (i - t0) / span) ? POS_WORD : NEG_WORD;
            check_dac("dac_data_ch1", exp, s1[i]);
            check_dac("dac_data_ch2", exp, s2[i]);
        end
        // whole runs only
        run = 0;
        for (int i = t0; i < t0 + 21 * span; i++) begin
            if (i > t0 && s1[i] != s1[i-1]) begin
                if (run % span != 0) begin
                    $display("error: run of %0d cycles is not a multiple of %0d", run, span);
                    err_count++;
                end
                run = 0;
            end
            run++;
        end
    endtask

    // ch2 off sits at midscale while ch1 keeps moving
    task automatic check_channel_gating();
        dac_word_t prev;
        int        toggles;
        toggles = 0;
        prev    = dac_data_ch1;
        repeat (GATE_CYCLES) begin
            @(negedge clk_low);
            check_dac("dac_data_ch2", MID_WORD, dac_data_ch2);
            if (dac_data_ch1 != prev) toggles++;
            prev = dac_data_ch1;
        end
        if (toggles == 0) begin
            $display("error: dac_data_ch1 did not toggle while ch2 was off");
            err_count++;
        end
    endtask

    ////////////////////
    // line dispatch

    task automatic run_test_line(input string op, input int a, input int v);
        reg_data_t rnd_data;
        if (op == "wr") begin
            bus_write(bus_addr_t'(a), reg_data_t'(v));
        end else if (op == "rd") begin
            bus_read(bus_addr_t'(a), reg_data_t'(v));
        end else if (op == "rnd") begin
            rnd_data = reg_data_t'($random(seed));
            bus_write(bus_addr_t'(a), rnd_data);
            bus_read(bus_addr_t'(a), rnd_data);
        end else if (op == "prot") begin
            set_protect(a, v[0]);
        end else if (op == "ext") begin
            set_ext_clk(v[0]);
        end else if (op == "on") begin
            if (a == 1) check_bit("ch1_on_off", v[0], ch1_on_off);
            else check_bit("ch2_on_off", v[0], ch2_on_off);
        end else if (op == "att") begin
            if (a == 1) check_atten("ch1_atten", atten_t'(v), ch1_atten);
            else check_atten("ch2_atten", atten_t'(v), ch2_atten);
        end else if (op == "pn") begin
            check_pn_sequence(a);
        end else if (op == "gate") begin
            check_channel_gating();
        end else begin
            $display("error: unknown operation %s in the test data", op);
            err_count++;
        end
    endtask

    ////////////////////
    // main sequence

    initial begin
        int    fd;
        int    n;
        int    a;
        int    v;
        int    errs_before;
        string line;
        string op;
        rst_n            = 1'b0;
        bus_cs_n         = 1'b1;
        bus_we_n         = 1'b1;
        bus_oe_n         = 1'b1;
        bus_addr         = '0;
        bus_wdata        = '0;
        hw_rev           = BOARD_REV;
        ext_clk_valid    = 1'b0;
        ch1_load_protect = 1'b0;
        ch2_load_protect = 1'b0;
        // read every line up front and skip # comment lines
        fd = $fopen("bench/bus_testdata.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open bench/bus_testdata.txt");
            err_count++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                if ($sscanf(line, "%s %h %h", op, a, v) == 3) begin
                    op_q.push_back(op);
                    addr_q.push_back(a);
                    val_q.push_back(v);
                end
            end
        end
        if (fd != 0) $fclose(fd);
        loaded = 1'b1;
        repeat (10) @(negedge clk_low);
        rst_n = 1'b1;
        repeat (2) @(negedge clk_low);
        for (int t = 0; t < op_q.size(); t++) begin
            errs_before = err_count;
            run_test_line(op_q[t], addr_q[t], val_q[t]);
            if (err_count == errs_before) begin
                $display("test %0d: %s %0h %0h ok", t + 1, op_q[t], addr_q[t], val_q[t]);
            end else begin
                $display("test %0d: %s %0h %0h failed", t + 1, op_q[t], addr_q[t], val_q[t]);
                test_fails++;
            end
        end
        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 op_q.size(), test_fails, err_count);
        if (err_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // budget grows with the number of data lines
    initial begin
        wait (loaded);
        repeat (op_q.size() * CYCLES_PER_LINE + WATCH_MARGIN) @(posedge clk_low);
        $display("error: watchdog expired before all test lines were done");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/bus_testdata.txt ====
# op addr value, hex; addr is the channel for prot/on/att and the rate for pn
# ops: wr rd rnd prot ext on att pn gate; hw_rev is tied to 5, status = 0x28 | bits
rd   000 00
rd   100 00
wr   000 01
wr   001 0a
wr   100 01
wr   101 05
on   1 1
att  1 a
on   2 1
att  2 5
rd   000 01
rd   001 0a
rd   100 01
rd   101 05
rnd  210 00
rnd  210 00
rnd  210 00
rd   200 05
rd   201 28
rd   3a0 00
rd   212 00
rd   002 00
rd   1ff 00
prot 1 1
on   1 0
on   2 1
rd   000 00
rd   201 2a
prot 1 0
on   1 1
rd   000 01
pn   0 00
pn   3 00
wr   100 00
gate 0 00
ext  0 1
rd   201 29

// ==== src.f ====
src/gen_pkg.sv
src/host_bus_decode.sv
src/channel_regs.sv
src/shared_regs.sv
src/pn3_gen.sv
src/readback_mux.sv
src/dac_word_map.sv
src/signal_gen_top.sv
bench/tb_signal_gen.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f src.f --top-module tb_signal_gen &&
./obj_dir/Vtb_signal_gen | tee /dev/stderr | grep -q "Simulation finished: PASS" &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }
